// File: dv/memSubsystem_testdata.mem
// op(1 wr, 2 rd, 3 flags {dataReady,tsre,tbre}, 4 status rd, 5 rd with stray wr)
// columns: op addr wdata expected, 16 hex digits per record
0001001012340000
0002001000001234
00017FFFBEEF0000
00027FFF0000BEEF
00018000CAFE0000
000280000000CAFE
0001BF040F0F0000
0002BF0400000F0F
0001BF0000C30000
0002BF00000000A5
0003000000030000
0004BF0100000001
0003000000060000
0004BF0100000002
0001BF0255550000
0002BF0200000000
0002BF0300000000
0005001099991234

// File: memSubsystem.f
rtl/memMapPkg.sv
rtl/sramPkg.sv
rtl/sramIf.sv
rtl/sramPhy.sv
rtl/comPort.sv
rtl/dataMemory.sv
rtl/memSubsystem.sv
dv/sramModel.sv
dv/memSubsystem_sva.sv
dv/memSubsystemTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = memSubsystemTb
FILELIST  = memSubsystem.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: dv/memSubsystemTb.sv
`timescale 1ns/1ps

module memSubsystemTb;
    import memMapPkg::*;
    import sramPkg::*;

    localparam int maxRecs = 32;
    localparam int lfsrPairs = 8;
    // Byte the UART stub puts on the bus
    localparam logic [7:0] stubByte = 8'hA5;

    logic clk;
    logic arstN;
    logic memRead;
    logic memWrite;
    memAddrT address;
    memWordT writeData;
    memWordT readData;
    logic readValid;
    logic busy;
    sramAddrT ram1Addr;
    sramAddrT ram2Addr;
    wire memWordT ram1Data;
    wire memWordT ram2Data;
    logic ram1En, ram1Oe, ram1We;
    logic ram2En, ram2Oe, ram2We;
    logic rdn, wrn;
    logic tbre, tsre, dataReady;

    logic [63:0] recs [0:maxRecs-1];
    int nRecs;
    int cycleCount;
    int cycleLimit;
    logic [31:0] lfsr;
    int comWrCount;
    memWordT comWrValue;

    memSubsystem u_dut (.*);

    sramModel ram1Model (.addr(ram1Addr), .data(ram1Data), .en(ram1En), .oe(ram1Oe),
                         .we(ram1We));
    sramModel ram2Model (.addr(ram2Addr), .data(ram2Data), .en(ram2En), .oe(ram2Oe),
                         .we(ram2We));

    //////////////////////////////////////////////////
    // Clock, watchdog, UART stub
    //////////////////////////////////////////////////

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: run exceeded %0d cycles", cycleLimit);
            $display("TEST FAILED");
            $fatal(1, "watchdog expired");
        end
    end

    // Stub byte on the shared bus during a UART read
    assign ram1Data = !rdn ? {8'h00, stubByte} : 'z;

    // Latch the written word at the end of the pulse
    always @(posedge wrn) begin
        comWrCount = comWrCount + 1;
        comWrValue = ram1Data;
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic stopWithFailure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic compareWord(input string what, input memWordT got, input memWordT exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("Error at %0t: %s got %h expected %h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic compareStatus(input comStatusT got, input comStatusT exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("Error at %0t: status got %h expected %h",
                                      $time, got, exp));
        end
    endtask

    // Status word from the flag rule
    function automatic comStatusT expectStatus();
        comStatusT s;
        s = '0;
        s[0] = tbre & tsre;
        s[1] = dataReady;
        return s;
    endfunction

    // Which device an address belongs to
    function automatic memTargetT targetOf(input memAddrT a);
        if (a < 16'h8000) return tgtRam1;
        if (a == 16'hBF00) return tgtComData;
        if (a == 16'hBF01) return tgtComStatus;
        if (a == 16'hBF02 || a == 16'hBF03) return tgtNone;
        return tgtRam2;
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawBits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    //////////////////////////////////////////////////
    // Bus operations
    //////////////////////////////////////////////////

    task automatic waitIdle();
        @(negedge clk);
        while (busy) @(negedge clk);
    endtask

    task automatic doWrite(input memAddrT a, input memWordT d);
        memWordT snap1;
        memWordT snap2;
        int cnt0;
        memTargetT tgt;
        snap1 = ram1Model.mem[a];
        snap2 = ram2Model.mem[a];
        cnt0 = comWrCount;
        tgt = targetOf(a);
        waitIdle();
        @(posedge clk);
        memWrite <= 1'b1;
        address <= a;
        writeData <= d;
        @(posedge clk);
        memWrite <= 1'b0;
        waitIdle();
        // Let the strobes and the drive release settle
        @(negedge clk);
        compareWord("ram1 model", ram1Model.mem[a], (tgt == tgtRam1) ? d : snap1);
        compareWord("ram2 model", ram2Model.mem[a], (tgt == tgtRam2) ? d : snap2);
        if (tgt == tgtComData) begin
            compareWord("wrn pulse count", 16'(comWrCount - cnt0), 16'd1);
            compareWord("UART write data", comWrValue, d);
        end else begin
            compareWord("stray wrn pulses", 16'(comWrCount - cnt0), 16'd0);
        end
    endtask

    // Optional stray write while busy, to the next address
    task automatic doRead(input memAddrT a, input memWordT exp, input bit isStatus,
                          input bit stray, input memWordT d);
        int base;
        int lat;
        memWordT snap1;
        memWordT snap2;
        snap1 = ram1Model.mem[a + 16'd1];
        snap2 = ram2Model.mem[a + 16'd1];
        waitIdle();
        @(posedge clk);
        memRead <= 1'b1;
        address <= a;
        @(posedge clk);
        memRead <= 1'b0;
        if (stray) begin
            memWrite <= 1'b1;
            address <= a + 16'd1;
            writeData <= d;
        end
        @(negedge clk);
        base = cycleCount;
        if (stray) begin
            @(posedge clk);
            memWrite <= 1'b0;
        end
        do @(negedge clk); while (!readValid);
        lat = cycleCount - base;
        if (lat != 3) begin
            stopWithFailure($sformatf("Error at %0t: readValid after %0d cycles, expected 3",
                                      $time, lat));
        end
        if (isStatus) begin
            compareStatus(readData, expectStatus());
        end else begin
            compareWord("read data", readData, exp);
        end
        if (stray) begin
            waitIdle();
            compareWord("ram1 after stray", ram1Model.mem[a + 16'd1], snap1);
            compareWord("ram2 after stray", ram2Model.mem[a + 16'd1], snap2);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        logic [15:0] op;
        logic [15:0] bits;
        memAddrT a;
        memWordT d;
        memWordT e;
        arstN = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        address = '0;
        writeData = '0;
        tbre = 1'b0;
        tsre = 1'b0;
        dataReady = 1'b0;
        cycleCount = 0;
        cycleLimit = 1000;
        comWrCount = 0;
        comWrValue = '0;
        lfsr = 32'h29fae16a;
        for (int i = 0; i < maxRecs; i++) recs[i] = '0;
        $readmemh("dv/memSubsystem_testdata.mem", recs);
        nRecs = 0;
        while (nRecs < maxRecs && recs[nRecs][63:48] != 16'h0000) nRecs++;
        cycleLimit = nRecs * 4 + lfsrPairs * 8 + 300;

        repeat (3) @(posedge clk);
        arstN <= 1'b1;

        for (int r = 0; r < nRecs; r++) begin
            op = recs[r][63:48];
            a = recs[r][47:32];
            d = recs[r][31:16];
            e = recs[r][15:0];
            case (op)
                16'h0001: doWrite(a, d);
                16'h0002: doRead(a, e, 1'b0, 1'b0, '0);
                16'h0003: begin
                    // Flags go through the two-flop sync
                    @(posedge clk);
                    {dataReady, tsre, tbre} <= d[2:0];
                    repeat (4) @(posedge clk);
                end
                16'h0004: doRead(a, e, 1'b1, 1'b0, '0);
                16'h0005: doRead(a, e, 1'b0, 1'b1, d);
                default: stopWithFailure($sformatf("Unknown operation %h in record %0d", op, r));
            endcase
        end

        // Random write then read pairs, both SRAM regions
        for (int p = 0; p < lfsrPairs; p++) begin
            drawBits(14, bits);
            a = p[0] ? {2'b11, bits[13:0]} : {2'b00, bits[13:0]};
            drawBits(16, d);
            doWrite(a, d);
            doRead(a, d, 1'b0, 1'b0, '0);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

// File: dv/memSubsystem_sva.sv
`timescale 1ns/1ps

module memSubsystemSva (
    input logic clk,
    input logic arstN,
    input logic memRead,
    input logic memWrite,
    input logic busy,
    input logic readValid,
    input logic ram1En,
    input logic ram1Oe,
    input logic ram1We,
    input logic ram2En,
    input logic ram2Oe,
    input logic ram2We
);

    // Only one chip selected at a time
    chipExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(!ram1En && !ram2En))
        else $error("both SRAM chips enabled");

    // Output and write enables never overlap
    ram1OeWe: assert property (@(posedge clk) disable iff (!arstN)
        !(!ram1Oe && !ram1We))
        else $error("SRAM 1 OE and WE both low");

    ram2OeWe: assert property (@(posedge clk) disable iff (!arstN)
        !(!ram2Oe && !ram2We))
        else $error("SRAM 2 OE and WE both low");

    // readValid set by the third edge after an accepted read
    // Seen high in the sample at the fourth edge
    readLatency: assert property (@(posedge clk) disable iff (!arstN)
        (memRead && !memWrite && !busy) |-> ##4 readValid)
        else $error("readValid not 3 cycles after read");

endmodule

bind dataMemory memSubsystemSva u_sva (
    .clk       (clk),
    .arstN     (arstN),
    .memRead   (memRead),
    .memWrite  (memWrite),
    .busy      (busy),
    .readValid (readValid),
    .ram1En    (ram1.en),
    .ram1Oe    (ram1.oe),
    .ram1We    (ram1.we),
    .ram2En    (ram2.en),
    .ram2Oe    (ram2.oe),
    .ram2We    (ram2.we)
);

// File: dv/sramModel.sv
`timescale 1ns/1ps

module sramModel (
    input  sramPkg::sramAddrT       addr,
    inout  wire memMapPkg::memWordT data,
    input  logic                    en,
    input  logic                    oe,
    input  logic                    we
);
    import memMapPkg::*;

    // 64K words, upper two address pins unused
    memWordT mem [0:65535];

    // Fill that depends on every address bit
    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 16'(i * 40503) ^ 16'h3C5A;
        end
    end

    // Read drive, WE low takes priority over OE
    assign data = (!en && !oe && we) ? mem[addr[15:0]] : 'z;

    // Asynchronous write while EN and WE are both low
    always @(en or we or addr or data) begin
        if (!en && !we) begin
            mem[addr[15:0]] = data;
        end
    end

endmodule

// File: rtl/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem (
    input  logic                    clk,
    input  logic                    arstN,
    // CPU side
    input  logic                    memRead,
    input  logic                    memWrite,
    input  memMapPkg::memAddrT      address,
    input  memMapPkg::memWordT      writeData,
    output memMapPkg::memWordT      readData,
    output logic                    readValid,
    output logic                    busy,
    // SRAM 1, data pins shared with the UART
    output sramPkg::sramAddrT       ram1Addr,
    inout  wire memMapPkg::memWordT ram1Data,
    output logic                    ram1En,
    output logic                    ram1Oe,
    output logic                    ram1We,
    // SRAM 2
    output sramPkg::sramAddrT       ram2Addr,
    inout  wire memMapPkg::memWordT ram2Data,
    output logic                    ram2En,
    output logic                    ram2Oe,
    output logic                    ram2We,
    // UART
    output logic                    rdn,
    output logic                    wrn,
    input  logic                    tbre,
    input  logic                    tsre,
    input  logic                    dataReady
);
    import sramPkg::*;

    sramIf ram1Bus ();
    sramIf ram2Bus ();

    comStatusT comStatus;
    logic      comRd;
    logic      comWr;

    // Decode and sequencing
    dataMemory uDataMemory (
        .clk       (clk),
        .arstN     (arstN),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .address   (address),
        .writeData (writeData),
        .comStatus (comStatus),
        // UART read data arrives through the SRAM 1 capture
        .comRdata  (ram1Bus.rdata),
        .readData  (readData),
        .readValid (readValid),
        .busy      (busy),
        .comRd     (comRd),
        .comWr     (comWr),
        .ram1      (ram1Bus.ctrl),
        .ram2      (ram2Bus.ctrl)
    );

    // Pad stages
    sramPhy uRam1Phy (
        .clk     (clk),
        .arstN   (arstN),
        .bus     (ram1Bus.phy),
        .pinAddr (ram1Addr),
        .pinData (ram1Data),
        .pinEn   (ram1En),
        .pinOe   (ram1Oe),
        .pinWe   (ram1We)
    );

    sramPhy uRam2Phy (
        .clk     (clk),
        .arstN   (arstN),
        .bus     (ram2Bus.phy),
        .pinAddr (ram2Addr),
        .pinData (ram2Data),
        .pinEn   (ram2En),
        .pinOe   (ram2Oe),
        .pinWe   (ram2We)
    );

    // UART strobes and status
    comPort uComPort (
        .clk       (clk),
        .arstN     (arstN),
        .comRd     (comRd),
        .comWr     (comWr),
        .tbre      (tbre),
        .tsre      (tsre),
        .dataReady (dataReady),
        .rdn       (rdn),
        .wrn       (wrn),
        .comStatus (comStatus)
    );

endmodule

// File: rtl/dataMemory.sv
`timescale 1ns/1ps

module dataMemory (
    input  logic               clk,
    input  logic               arstN,
    input  logic               memRead,
    input  logic               memWrite,
    input  memMapPkg::memAddrT address,
    input  memMapPkg::memWordT writeData,
    input  sramPkg::comStatusT comStatus,
    input  memMapPkg::memWordT comRdata,
    output memMapPkg::memWordT readData,
    output logic               readValid,
    output logic               busy,
    output logic               comRd,
    output logic               comWr,
    sramIf.ctrl                ram1,
    sramIf.ctrl                ram2
);
    import memMapPkg::*;
    import sramPkg::*;

    accStateT  state;
    // Target of the incoming request
    memTargetT reqTgt;
    // Latched request
    memTargetT tgtQ;
    logic      isReadQ;
    // Read source for the capture cycle
    memTargetT capTgt;
    logic      postPend;
    logic      postRead;
    logic      accept;

    // Requests only count in idle
    assign accept = (state == stIdle) && (memRead || memWrite);
    assign busy   = (state != stIdle);

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////

    always_comb begin
        if (address < ram1Upper) begin
            reqTgt = tgtRam1;
        end else if (address == com1Data) begin
            reqTgt = tgtComData;
        end else if (address == com1Status) begin
            reqTgt = tgtComStatus;
        end else if (address == com2Data || address == com2Status) begin
            // No COM2 device fitted
            reqTgt = tgtNone;
        end else begin
            reqTgt = tgtRam2;
        end
    end

    //////////////////////////////////////////////////
    // Access sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state      <= stIdle;
            tgtQ       <= tgtNone;
            isReadQ    <= 1'b0;
            capTgt     <= tgtNone;
            postPend   <= 1'b0;
            postRead   <= 1'b0;
            readValid  <= 1'b0;
            comRd      <= 1'b0;
            comWr      <= 1'b0;
            ram1.drive <= 1'b0;
            ram1.en    <= 1'b1;
            ram1.oe    <= 1'b1;
            ram1.we    <= 1'b1;
            ram2.drive <= 1'b0;
            ram2.en    <= 1'b1;
            ram2.oe    <= 1'b1;
            ram2.we    <= 1'b1;
        end else begin
            // One cycle after the strobes end
            readValid <= postPend && postRead;
            postPend  <= 1'b0;
            if (postPend) begin
                // Hold data past the WE rising edge, then release
                ram1.drive <= 1'b0;
                ram2.drive <= 1'b0;
            end
            case (state)
                stIdle: begin
                    if (accept) begin
                        state      <= stSetup;
                        tgtQ       <= reqTgt;
                        // Write wins if both are high
                        isReadQ    <= !memWrite;
                        // UART write also uses the SRAM 1 data pins
                        ram1.drive <= memWrite &&
                                      (reqTgt == tgtRam1 || reqTgt == tgtComData);
                        ram2.drive <= memWrite && (reqTgt == tgtRam2);
                        // Chip select ahead of the strobes
                        ram1.en    <= (reqTgt != tgtRam1);
                        ram2.en    <= (reqTgt != tgtRam2);
                    end
                end
                stSetup: begin
                    state   <= stStrobe;
                    ram1.oe <= !(tgtQ == tgtRam1 && isReadQ);
                    ram1.we <= !(tgtQ == tgtRam1 && !isReadQ);
                    ram2.oe <= !(tgtQ == tgtRam2 && isReadQ);
                    ram2.we <= !(tgtQ == tgtRam2 && !isReadQ);
                    comRd   <= (tgtQ == tgtComData) && isReadQ;
                    comWr   <= (tgtQ == tgtComData) && !isReadQ;
                end
                stStrobe: begin
                    state    <= stIdle;
                    // All strobes back off together
                    ram1.en  <= 1'b1;
                    ram1.oe  <= 1'b1;
                    ram1.we  <= 1'b1;
                    ram2.en  <= 1'b1;
                    ram2.oe  <= 1'b1;
                    ram2.we  <= 1'b1;
                    comRd    <= 1'b0;
                    comWr    <= 1'b0;
                    postPend <= 1'b1;
                    postRead <= isReadQ;
                    capTgt   <= tgtQ;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // Address and write data for both chips
    always_ff @(posedge clk) begin
        if (accept) begin
            ram1.addr  <= {2'b00, address};
            ram2.addr  <= {2'b00, address};
            ram1.wdata <= writeData;
            ram2.wdata <= writeData;
        end
    end

    //////////////////////////////////////////////////
    // Read data steering
    //////////////////////////////////////////////////

    // Valid in the readValid cycle only
    always_comb begin
        case (capTgt)
            tgtRam1:      readData = ram1.rdata;
            tgtRam2:      readData = ram2.rdata;
            // UART is byte wide
            tgtComData:   readData = {8'h00, comRdata[7:0]};
            tgtComStatus: readData = comStatus;
            default:      readData = '0;
        endcase
    end

endmodule

// File: rtl/comPort.sv
`timescale 1ns/1ps

module comPort (
    input  logic               clk,
    input  logic               arstN,
    input  logic               comRd,
    input  logic               comWr,
    input  logic               tbre,
    input  logic               tsre,
    input  logic               dataReady,
    output logic               rdn,
    output logic               wrn,
    output sramPkg::comStatusT comStatus
);
    import sramPkg::*;

    // Flag order {dataReady, tsre, tbre}
    logic [2:0] flagMeta;
    logic [2:0] flagSync;

    //////////////////////////////////////////////////
    // Flag sync and strobe registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flagMeta <= '0;
            flagSync <= '0;
            rdn      <= 1'b1;
            wrn      <= 1'b1;
        end else begin
            // Two-flop sync of async UART flags
            flagMeta <= {dataReady, tsre, tbre};
            flagSync <= flagMeta;
            // Same delay as the SRAM pad stage
            rdn      <= !comRd;
            wrn      <= !comWr;
        end
    end

    // Status word, unused bits read as zero
    always_comb begin
        comStatus             = '0;
        comStatus[txEmptyBit] = flagSync[0] & flagSync[1];
        comStatus[rxReadyBit] = flagSync[2];
    end

endmodule

// File: rtl/sramPhy.sv
`timescale 1ns/1ps

module sramPhy (
    input  logic                    clk,
    input  logic                    arstN,
    sramIf.phy                      bus,
    output sramPkg::sramAddrT       pinAddr,
    inout  wire memMapPkg::memWordT pinData,
    output logic                    pinEn,
    output logic                    pinOe,
    output logic                    pinWe
);
    import memMapPkg::*;

    // Registered write data and its tristate control
    memWordT dataQ;
    logic    driveQ;

    //////////////////////////////////////////////////
    // Tristate data pins
    //////////////////////////////////////////////////

    // Released whenever the chip or the UART may drive
    assign pinData = driveQ ? dataQ : 'z;

    //////////////////////////////////////////////////
    // Pad registers
    //////////////////////////////////////////////////

    // Strobes and drive enable, idle at the inactive level
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            driveQ <= 1'b0;
            pinEn  <= 1'b1;
            pinOe  <= 1'b1;
            pinWe  <= 1'b1;
        end else begin
            driveQ <= bus.drive;
            pinEn  <= bus.en;
            pinOe  <= bus.oe;
            pinWe  <= bus.we;
        end
    end

    // Address, write data and read capture
    always_ff @(posedge clk) begin
        pinAddr   <= bus.addr;
        dataQ     <= bus.wdata;
        // Sampled every edge, controller picks the right one
        bus.rdata <= pinData;
    end

endmodule

// File: rtl/sramIf.sv
`timescale 1ns/1ps

interface sramIf;
    import memMapPkg::*;
    import sramPkg::*;

    // Chip address as it goes onto the pins
    sramAddrT addr;
    // Write data toward the pads
    memWordT  wdata;
    // Pad capture back toward the controller
    memWordT  rdata;
    // Pad stage owns the data pins while high
    logic     drive;
    // Active-low chip enable, output enable, write enable
    logic     en;
    logic     oe;
    logic     we;

    // Controller side
    modport ctrl (output addr, wdata, drive, en, oe, we, input rdata);

    // Pad register side
    modport phy (input addr, wdata, drive, en, oe, we, output rdata);

endinterface

// File: rtl/sramPkg.sv
package sramPkg;

    // Chip address on the board pins
    // Upper two bits unused on this board
    typedef logic [17:0] sramAddrT;

    //////////////////////////////////////////////////
    // Access sequencing
    //////////////////////////////////////////////////

    // Idle, then address setup, then strobe phase
    typedef enum logic [1:0] {
        stIdle,
        stSetup,
        stStrobe
    } accStateT;

    //////////////////////////////////////////////////
    // UART status word
    //////////////////////////////////////////////////

    typedef logic [15:0] comStatusT;

    // Transmitter fully empty (tbre and tsre)
    localparam int txEmptyBit = 0;
    // Receive byte waiting
    localparam int rxReadyBit = 1;

endpackage

// File: rtl/memMapPkg.sv
package memMapPkg;

    // CPU-side address and data word
    typedef logic [15:0] memAddrT;
    typedef logic [15:0] memWordT;

    //////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////

    // Everything below this goes to SRAM 1
    localparam memAddrT ram1Upper  = 16'h8000;

    // COM1 registers on the shared SRAM 1 bus
    localparam memAddrT com1Data   = 16'hBF00;
    localparam memAddrT com1Status = 16'hBF01;

    // COM2 window, decoded but no device behind it
    localparam memAddrT com2Data   = 16'hBF02;
    localparam memAddrT com2Status = 16'hBF03;

    // Decoded target of one access
    typedef enum logic [2:0] {
        tgtRam1,
        tgtRam2,
        tgtComData,
        tgtComStatus,
        tgtNone
    } memTargetT;

endpackage
